/* hw/sseg_pkg.sv */
`default_nettype none

package sseg_pkg;

    ////////////////////////////////////////
    // Display geometry
    ////////////////////////////////////////

    localparam int NUM_DIGITS = 4;
    localparam int BIN_W      = 14;
    localparam int BCD_W      = 4;
    localparam int SEG_W      = 8;                         // {dp, g, f, e, d, c, b, a}.

    localparam logic [BIN_W-1:0] MAX_VALUE = 14'd9999;

    ////////////////////////////////////////
    // Segment codes, active low
    ////////////////////////////////////////

    localparam logic [SEG_W-1:0] SEG_CODES [10] = '{
        8'hC0,                                             // 0.
        8'hF9,
        8'hA4,
        8'hB0,
        8'h99,
        8'h92,
        8'h82,
        8'hF8,
        8'h80,
        8'h90                                              // 9.
    };

    localparam logic [SEG_W-1:0] SEG_MINUS = 8'hBF;        // Segment g only.
    localparam logic [SEG_W-1:0] SEG_BLANK = 8'hFF;

    typedef enum logic {ST_IDLE, ST_CONVERT} ctrl_state_t;

endpackage

`default_nettype wire

/* hw/wb_regs_pkg.sv */
`default_nettype none

package wb_regs_pkg;

    localparam int WB_ADR_W = 4;                           // Byte address.
    localparam int WB_DAT_W = 32;

    // Register map.
    localparam logic [WB_ADR_W-1:0] ADR_VALUE  = 4'h0;
    localparam logic [WB_ADR_W-1:0] ADR_CTRL   = 4'h4;
    localparam logic [WB_ADR_W-1:0] ADR_STATUS = 4'h8;

    typedef enum logic [1:0]
    {
        SEL_VALUE,
        SEL_CTRL,
        SEL_STATUS,
        SEL_NONE
    } reg_sel_t;

endpackage

`default_nettype wire

/* hw/bcd_conv_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bcd_conv_if;

    logic                         o_start;
    logic [sseg_pkg::BIN_W-1:0]   bin;
    logic                         ready;
    logic                         done;                    // Digits valid this cycle.
    logic [sseg_pkg::BCD_W-1:0]   bcd3, bcd2, bcd1, bcd0;

    modport ctrl
    (
        output o_start, bin,
        input  ready, done, bcd3, bcd2, bcd1, bcd0
    );

    modport conv
    (
        input  o_start, bin,
        output ready, done, bcd3, bcd2, bcd1, bcd0
    );

endinterface

`default_nettype wire

/* hw/bin_to_bcd.sv */
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd
    (
        input  wire logic   i_clk,
        input  wire logic   i_rst,
        bcd_conv_if.conv    conv
    );

    // BCD digits above, binary operand below, shifted left as one word.
    typedef logic [sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W+sseg_pkg::BIN_W-1:0] dabble_t;

    typedef enum logic [1:0] {CV_IDLE, CV_SHIFT, CV_DONE} conv_state_t;

    conv_state_t r_state;
    logic [$clog2(sseg_pkg::BIN_W)-1:0] r_cnt;
    dabble_t r_shift;

    // One shift-and-add-three step.
    function automatic dabble_t dabble_step(input dabble_t v);
        dabble_t t;
        t = v;
        for (int i = 0; i < sseg_pkg::NUM_DIGITS; i++)
        begin
            if (t[sseg_pkg::BIN_W + i*sseg_pkg::BCD_W +: sseg_pkg::BCD_W] >= 4'd5)
                t[sseg_pkg::BIN_W + i*sseg_pkg::BCD_W +: sseg_pkg::BCD_W] =
                    t[sseg_pkg::BIN_W + i*sseg_pkg::BCD_W +: sseg_pkg::BCD_W] + 4'd3;
        end
        return t << 1;
    endfunction

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= CV_IDLE;
            r_cnt   <= '0;
        end
        else
        begin
            case (r_state)
                CV_IDLE:
                    if (conv.o_start)
                    begin
                        r_cnt   <= '0;
                        r_state <= CV_SHIFT;
                    end
                CV_SHIFT:
                begin
                    r_cnt <= r_cnt + 1'b1;
                    if (r_cnt == sseg_pkg::BIN_W - 1)
                        r_state <= CV_DONE;                // Last bit shifted in.
                end
                default:
                    r_state <= CV_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (r_state == CV_IDLE && conv.o_start)
            r_shift <= dabble_t'(conv.bin);
        else if (r_state == CV_SHIFT)
            r_shift <= dabble_step(r_shift);
    end

    assign conv.ready = (r_state == CV_IDLE);
    assign conv.done  = (r_state == CV_DONE);

    assign conv.bcd0 = r_shift[sseg_pkg::BIN_W + 0*sseg_pkg::BCD_W +: sseg_pkg::BCD_W];
    assign conv.bcd1 = r_shift[sseg_pkg::BIN_W + 1*sseg_pkg::BCD_W +: sseg_pkg::BCD_W];
    assign conv.bcd2 = r_shift[sseg_pkg::BIN_W + 2*sseg_pkg::BCD_W +: sseg_pkg::BCD_W];
    assign conv.bcd3 = r_shift[sseg_pkg::BIN_W + 3*sseg_pkg::BCD_W +: sseg_pkg::BCD_W];

endmodule

`default_nettype wire

/* hw/digit_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_scan
    #(
        parameter int P_SCAN_BITS = 18
    )
    (
        input  wire logic                                         i_clk,
        input  wire logic                                         i_rst,
        input  wire logic [sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W-1:0] i_bcd,
        input  wire logic                                         i_neg,
        output logic [sseg_pkg::NUM_DIGITS-1:0]                   o_ldsel,    // Active high.
        output logic [sseg_pkg::SEG_W-1:0]                        o_sseg_n    // Active low.
    );

    logic [P_SCAN_BITS-1:0] r_cnt;
    logic [$clog2(sseg_pkg::NUM_DIGITS)-1:0] r_idx;
    logic [sseg_pkg::BCD_W-1:0] w_digit;

    ////////////////////////////////////////
    // Refresh counter and digit index
    ////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_cnt <= '0;
            r_idx <= '0;
        end
        else
        begin
            r_cnt <= r_cnt + 1'b1;
            if (&r_cnt)
            begin
                if (r_idx == sseg_pkg::NUM_DIGITS - 1)
                    r_idx <= '0;
                else
                    r_idx <= r_idx + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Select and segment decode
    ////////////////////////////////////////

    assign w_digit = i_bcd[r_idx*sseg_pkg::BCD_W +: sseg_pkg::BCD_W];

    always_comb
    begin
        o_ldsel        = '0;
        o_ldsel[r_idx] = 1'b1;

        if (i_neg && r_idx == sseg_pkg::NUM_DIGITS - 1)
            o_sseg_n = sseg_pkg::SEG_MINUS;                // Sign takes the top digit.
        else if (w_digit > 4'd9)
            o_sseg_n = sseg_pkg::SEG_BLANK;
        else
            o_sseg_n = sseg_pkg::SEG_CODES[w_digit];
    end

endmodule

`default_nettype wire

/* hw/sseg_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sseg_ctrl
    (
        input  wire logic                                            i_clk,
        input  wire logic                                            i_rst,
        input  wire logic [sseg_pkg::BIN_W-1:0]                      i_value,
        input  wire logic                                            i_neg,
        bcd_conv_if.ctrl                                             conv,
        output logic [sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W-1:0]      o_bcd,
        output logic                                                 o_neg,
        output logic                                                 o_idle
    );

    sseg_pkg::ctrl_state_t r_state, w_state_next;

    logic r_neg_cap, w_neg_cap_next;                       // Sign of the sample in flight.
    logic [sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W-1:0] r_bcd, w_bcd_next;
    logic r_neg, w_neg_next;

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state   <= sseg_pkg::ST_IDLE;
            r_neg_cap <= 1'b0;
            r_bcd     <= '0;
            r_neg     <= 1'b0;
        end
        else
        begin
            r_state   <= w_state_next;
            r_neg_cap <= w_neg_cap_next;
            r_bcd     <= w_bcd_next;
            r_neg     <= w_neg_next;
        end
    end

    // The converter latches the operand itself on the start cycle.
    assign conv.bin = i_value;

    always_comb
    begin
        w_state_next   = r_state;
        w_neg_cap_next = r_neg_cap;
        w_bcd_next     = r_bcd;
        w_neg_next     = r_neg;
        conv.o_start   = 1'b0;
        o_idle         = 1'b0;

        case (r_state)
            sseg_pkg::ST_IDLE:
            begin
                o_idle = 1'b1;
                if (conv.ready)
                begin
                    conv.o_start   = 1'b1;
                    w_neg_cap_next = i_neg;
                    w_state_next   = sseg_pkg::ST_CONVERT;
                end
            end
            sseg_pkg::ST_CONVERT:
            begin
                if (conv.done)
                begin
                    // Digits and sign change together.
                    w_bcd_next   = {conv.bcd3, conv.bcd2, conv.bcd1, conv.bcd0};
                    w_neg_next   = r_neg_cap;
                    w_state_next = sseg_pkg::ST_IDLE;
                end
            end
            default:
                w_state_next = sseg_pkg::ST_IDLE;
        endcase
    end

    assign o_bcd = r_bcd;
    assign o_neg = r_neg;

endmodule

`default_nettype wire

/* hw/sseg_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sseg_wb_regs
    (
        input  wire logic                                         i_clk,
        input  wire logic                                         i_rst,
        input  wire logic                                         i_wb_cyc,
        input  wire logic                                         i_wb_stb,
        input  wire logic                                         i_wb_we,
        input  wire logic [wb_regs_pkg::WB_ADR_W-1:0]             i_wb_adr,
        input  wire logic [wb_regs_pkg::WB_DAT_W-1:0]             i_wb_dat,
        output logic [wb_regs_pkg::WB_DAT_W-1:0]                  o_wb_dat,
        output logic                                              o_wb_ack,
        input  wire logic [sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W-1:0] i_bcd,
        input  wire logic                                         i_idle,
        output logic [sseg_pkg::BIN_W-1:0]                        o_value,
        output logic                                              o_neg
    );

    wb_regs_pkg::reg_sel_t w_sel;
    logic w_req;                                           // New access, not yet acked.
    logic [sseg_pkg::BIN_W-1:0] w_wr_bin;
    logic [wb_regs_pkg::WB_DAT_W-1:0] w_rd_dat;

    always_comb
    begin
        case (i_wb_adr)
            wb_regs_pkg::ADR_VALUE:  w_sel = wb_regs_pkg::SEL_VALUE;
            wb_regs_pkg::ADR_CTRL:   w_sel = wb_regs_pkg::SEL_CTRL;
            wb_regs_pkg::ADR_STATUS: w_sel = wb_regs_pkg::SEL_STATUS;
            default:                 w_sel = wb_regs_pkg::SEL_NONE;
        endcase
    end

    assign w_req    = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign w_wr_bin = i_wb_dat[sseg_pkg::BIN_W-1:0];

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            o_wb_ack <= 1'b0;
            o_value  <= '0;
            o_neg    <= 1'b0;
        end
        else
        begin
            o_wb_ack <= w_req;
            if (w_req && i_wb_we)
            begin
                if (w_sel == wb_regs_pkg::SEL_VALUE)
                    o_value <= (w_wr_bin > sseg_pkg::MAX_VALUE) ? sseg_pkg::MAX_VALUE : w_wr_bin;
                else if (w_sel == wb_regs_pkg::SEL_CTRL)
                    o_neg <= i_wb_dat[0];
            end
        end
    end

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb
    begin
        w_rd_dat = '0;
        case (w_sel)
            wb_regs_pkg::SEL_VALUE:  w_rd_dat[sseg_pkg::BIN_W-1:0] = o_value;
            wb_regs_pkg::SEL_CTRL:   w_rd_dat[0] = o_neg;
            wb_regs_pkg::SEL_STATUS:
            begin
                w_rd_dat[sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W-1:0] = i_bcd;
                w_rd_dat[sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W]     = i_idle;
            end
            default: w_rd_dat = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (w_req)
            o_wb_dat <= w_rd_dat;                          // Held through the ack cycle.
    end

endmodule

`default_nettype wire

/* hw/sseg_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sseg_wb_top
    #(
        parameter int P_SCAN_BITS = 18
    )
    (
        input  wire logic                               i_clk,
        input  wire logic                               i_rst,
        input  wire logic                               i_wb_cyc,
        input  wire logic                               i_wb_stb,
        input  wire logic                               i_wb_we,
        input  wire logic [wb_regs_pkg::WB_ADR_W-1:0]   i_wb_adr,
        input  wire logic [wb_regs_pkg::WB_DAT_W-1:0]   i_wb_dat,
        output logic [wb_regs_pkg::WB_DAT_W-1:0]        o_wb_dat,
        output logic                                    o_wb_ack,
        output logic [sseg_pkg::SEG_W-1:0]              o_sseg_n,
        output logic [sseg_pkg::NUM_DIGITS-1:0]         o_ldsel
    );

    logic [sseg_pkg::BIN_W-1:0] w_value;
    logic w_neg;                                           // Host sign flag.
    logic [sseg_pkg::NUM_DIGITS*sseg_pkg::BCD_W-1:0] w_bcd;
    logic w_disp_neg;                                      // Sign latched with w_bcd.
    logic w_idle;

    bcd_conv_if u_conv_if ();

    sseg_wb_regs u_regs
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
        .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
        .i_bcd(w_bcd), .i_idle(w_idle),
        .o_value(w_value), .o_neg(w_neg)
    );

    sseg_ctrl u_ctrl
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_value(w_value), .i_neg(w_neg),
        .conv(u_conv_if.ctrl),
        .o_bcd(w_bcd), .o_neg(w_disp_neg), .o_idle(w_idle)
    );

    bin_to_bcd u_bin_to_bcd
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .conv(u_conv_if.conv)
    );

    digit_scan #(.P_SCAN_BITS(P_SCAN_BITS)) u_scan
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_bcd(w_bcd), .i_neg(w_disp_neg),
        .o_ldsel(o_ldsel), .o_sseg_n(o_sseg_n)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
    (
        output logic o_clk
    );

    initial
    begin
        o_clk = 1'b0;
        forever
            #10 o_clk = ~o_clk;                            // 20 ns period.
    end

endmodule

`default_nettype wire

/* tb/tb_sseg.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sseg;

    localparam int ADR_W       = wb_regs_pkg::WB_ADR_W;
    localparam int DAT_W       = wb_regs_pkg::WB_DAT_W;
    localparam int NDIG        = sseg_pkg::NUM_DIGITS;
    localparam int SCAN_BITS   = 3;
    localparam int SCAN_PERIOD = 1 << SCAN_BITS;
    localparam int NUM_ITER    = 24;
    localparam int CONV_MAX    = 2 * (sseg_pkg::BIN_W + 2); // Worst-case display update.
    localparam int BUS_SLACK   = 6;
    localparam int CYCLE_LIMIT = 200 * (CONV_MAX + 8 * NDIG);
    localparam logic [ADR_W-1:0] ADR_UNMAPPED = 4'hC;

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic [DAT_W-1:0] wb_wdat;
    logic [DAT_W-1:0] wb_rdat;
    logic wb_ack;
    logic [sseg_pkg::SEG_W-1:0] sseg_n;
    logic [NDIG-1:0] ldsel;

    logic [sseg_pkg::BIN_W-1:0] exp_value;                 // Model of VALUE.
    logic exp_neg;                                         // Model of CTRL bit 0.
    int unsigned cycle_cnt = 0;

    tb_clk_gen u_clk_gen (.o_clk(clk));

    sseg_wb_top #(.P_SCAN_BITS(SCAN_BITS)) dut0
    (
        .i_clk(clk), .i_rst(rst),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_adr(wb_adr), .i_wb_dat(wb_wdat),
        .o_wb_dat(wb_rdat), .o_wb_ack(wb_ack),
        .o_sseg_n(sseg_n), .o_ldsel(ldsel)
    );

    ////////////////////////////////////////
    // Failure and compare tasks
    ////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_wb_word(input string name, input logic [DAT_W-1:0] got,
                                 input logic [DAT_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got 0x%h expected 0x%h",
                                $time, name, got, exp));
    endtask

    task automatic check_seg(input string name, input logic [sseg_pkg::SEG_W-1:0] got,
                             input logic [sseg_pkg::SEG_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got 0x%h expected 0x%h",
                                $time, name, got, exp));
    endtask

    task automatic check_ldsel(input string name, input logic [NDIG-1:0] got,
                               input logic [NDIG-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                $time, name, got, exp));
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [sseg_pkg::BIN_W-1:0] model_value(input logic [DAT_W-1:0] wdat);
        logic [sseg_pkg::BIN_W-1:0] low;
        low = wdat[sseg_pkg::BIN_W-1:0];                   // Upper bits are dropped.
        if (low > sseg_pkg::MAX_VALUE)
            return sseg_pkg::MAX_VALUE;
        return low;
    endfunction

    function automatic logic [sseg_pkg::BCD_W-1:0] model_digit(input int idx);
        int v;
        v = int'(exp_value);
        for (int i = 0; i < idx; i++)
            v = v / 10;
        return 4'(v % 10);
    endfunction

    function automatic logic [DAT_W-1:0] model_digits();
        return {16'h0, model_digit(3), model_digit(2), model_digit(1), model_digit(0)};
    endfunction

    function automatic logic [sseg_pkg::SEG_W-1:0] model_seg(input int idx);
        if (exp_neg && idx == NDIG - 1)
            return sseg_pkg::SEG_MINUS;
        return sseg_pkg::SEG_CODES[model_digit(idx)];
    endfunction

    ////////////////////////////////////////
    // Bus and display tasks
    ////////////////////////////////////////

    // Called on a falling edge, returns on the falling edge after the ack.
    task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [DAT_W-1:0] wdat, output logic [DAT_W-1:0] rdat);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_adr  = adr;
        wb_wdat = wdat;
        do
            @(negedge clk);
        while (!wb_ack);
        rdat   = wb_rdat;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] wdat);
        logic [DAT_W-1:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic wait_display(input int unsigned t_write);
        logic [DAT_W-1:0] rdat;
        wb_read(wb_regs_pkg::ADR_STATUS, rdat);
        while ((rdat & 32'h0000_FFFF) !== model_digits())
        begin
            if (cycle_cnt - t_write > CONV_MAX + BUS_SLACK)
                abort_run("STATUS digits did not follow the VALUE write in time.");
            wb_read(wb_regs_pkg::ADR_STATUS, rdat);
        end
        check_wb_word("STATUS[31:17]", rdat & 32'hFFFE_0000, '0);
        repeat (CONV_MAX) @(negedge clk);                  // Lets a new sign reach the display.
    endtask

    task automatic scan_check();
        logic [NDIG-1:0] prev;
        int idx;
        int changes;
        int gap;
        prev    = ldsel;
        idx     = 0;
        changes = 0;
        gap     = 0;
        for (int i = NDIG - 1; i >= 0; i--)
            if (prev[i])
                idx = i;
        check_ldsel("o_ldsel", prev, NDIG'(1) << idx);
        while (changes < 2 * NDIG)
        begin
            @(negedge clk);
            gap++;
            if (ldsel !== prev)
            begin
                idx = (idx + 1) % NDIG;
                check_ldsel("o_ldsel", ldsel, NDIG'(1) << idx);
                if (changes > 0 && gap != SCAN_PERIOD)
                    abort_run($sformatf("Digit select advanced after %0d cycles.", gap));
                prev = ldsel;
                gap  = 0;
                changes++;
            end
            check_seg("o_sseg_n", sseg_n, model_seg(idx));
        end
    endtask

    task automatic run_case(input logic [DAT_W-1:0] ctrl_raw, input logic [DAT_W-1:0] value_raw);
        logic [DAT_W-1:0] rdat;
        int unsigned t_write;
        wb_write(wb_regs_pkg::ADR_CTRL, ctrl_raw);
        exp_neg = ctrl_raw[0];
        wb_read(wb_regs_pkg::ADR_CTRL, rdat);
        check_wb_word("CTRL", rdat, {31'h0, exp_neg});
        wb_write(wb_regs_pkg::ADR_VALUE, value_raw);
        t_write   = cycle_cnt;
        exp_value = model_value(value_raw);
        wb_read(wb_regs_pkg::ADR_VALUE, rdat);
        check_wb_word("VALUE", rdat, {18'h0, exp_value});
        wait_display(t_write);
        scan_check();
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            abort_run("Timeout: the run did not finish within the cycle limit.");
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        logic [DAT_W-1:0] rdat;
        logic [DAT_W-1:0] raw;
        void'($urandom(32'h28f2798c));
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_wdat   = '0;
        exp_value = '0;
        exp_neg   = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_flag("o_wb_ack", wb_ack, 1'b0);
        check_ldsel("o_ldsel", ldsel, 4'b0001);
        check_seg("o_sseg_n", sseg_n, sseg_pkg::SEG_CODES[0]);
        rst = 1'b0;
        wb_read(wb_regs_pkg::ADR_STATUS, rdat);
        check_wb_word("STATUS digits", rdat & 32'h0000_FFFF, '0);

        // Saturation and upper bits.
        run_case(32'h0, 32'd9999);
        run_case(32'h0, 32'd10000);
        run_case(32'hFFFF_FFFE, 32'hFFFF_FFFF);
        run_case(32'h0, 32'd0);

        run_case(32'h1, 32'd1234);                         // Minus on digit 3.
        run_case(32'h0, 32'd1234);

        for (int n = 0; n < NUM_ITER; n++)
        begin
            if ($urandom_range(3, 0) == 0)
                raw = $urandom;
            else
                raw = 32'($urandom_range(9999, 0));
            run_case($urandom, raw);
        end

        // Unmapped address.
        wb_write(ADR_UNMAPPED, $urandom);
        wb_read(wb_regs_pkg::ADR_VALUE, rdat);
        check_wb_word("VALUE", rdat, {18'h0, exp_value});
        wb_read(wb_regs_pkg::ADR_CTRL, rdat);
        check_wb_word("CTRL", rdat, {31'h0, exp_neg});
        wb_read(ADR_UNMAPPED, rdat);
        check_wb_word("unmapped read", rdat, '0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/sseg_pkg.sv
hw/wb_regs_pkg.sv
hw/bcd_conv_if.sv
hw/bin_to_bcd.sv
hw/digit_scan.sv
hw/sseg_ctrl.sv
hw/sseg_wb_regs.sv
hw/sseg_wb_top.sv
tb/tb_clk_gen.sv
tb/tb_sseg.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sseg
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
